// ==== soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// ========================================
// Memory map
// ========================================
// Bases compared against the masked address
`define SOC_RAM_BASE            32'h8000_0000
`define SOC_CLINT_BASE          32'h3000_0000
`define SOC_PERIPH_BASE         32'h2000_0000

// Main RAM, 32-bit words
`define SOC_RAM_DEPTH           1024
`define SOC_RAM_LATENCY         4

// ========================================
// CLINT offsets, high word at offset + 4
// ========================================
`define SOC_CLINT_MSIP_OFF      16'h0000
`define SOC_CLINT_MTIMECMP_OFF  16'h4000
`define SOC_CLINT_MTIME_OFF     16'hBFF8

// ========================================
// GPIO
// ========================================
`define SOC_GPIO_W              32
`define SOC_GPIO_OUT_OFF        12'h000
`define SOC_GPIO_OE_OFF         12'h004
`define SOC_GPIO_IN_OFF         12'h008
`define SOC_GPIO_IP_OFF         12'h00C
`define SOC_GPIO_IE_OFF         12'h010

`endif

// ==== soc_pkg.sv ====
package soc_pkg;

  // ========================================
  // Bus structs
  // ========================================
  // CPU request, wstrb of zero is a read
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  // Target response
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } bus_rsp_t;

  // ========================================
  // Decode enums
  // ========================================
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_RAM,
    REGION_CLINT,
    REGION_PERIPH
  } region_e;

  // Peripheral slots, 4 KB each, addr[15:12]
  typedef enum logic [3:0] {
    SLOT_UART0 = 4'h0,
    SLOT_UART1 = 4'h1,
    SLOT_SPI0  = 4'h2,
    SLOT_I2C0  = 4'h3,
    SLOT_GPIO  = 4'h4,
    SLOT_PWM   = 4'h5,
    SLOT_TIMER = 4'h6,
    SLOT_PLIC  = 4'h7,
    SLOT_WDT   = 4'h8,
    SLOT_DMA   = 4'h9,
    SLOT_VGA   = 4'hD
  } periph_slot_e;

endpackage

// ==== soc_bus_fabric.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_bus_fabric (
  input  soc_pkg::bus_req_t req_i,
  input  soc_pkg::bus_rsp_t ram_rsp_i,
  input  logic [31:0]       clint_rdata_i,
  input  logic [31:0]       gpio_rdata_i,
  output logic              ram_sel_o,
  output logic              clint_sel_o,
  output logic              gpio_sel_o,
  output soc_pkg::bus_rsp_t rsp_o
);

  import soc_pkg::*;

  // RAM decodes on the top bit only
  localparam logic [31:0] RAM_MASK    = 32'h8000_0000;
  // CLINT and peripherals decode on the top nibble
  localparam logic [31:0] REGION_MASK = 32'hF000_0000;

  region_e      region;
  periph_slot_e slot;

  // ========================================
  // Region decode
  // ========================================
  always_comb begin
    region = REGION_NONE;
    if (req_i.valid) begin
      // RAM has priority over the nibble matches
      if ((req_i.addr & RAM_MASK) == `SOC_RAM_BASE) begin
        region = REGION_RAM;
      end else if ((req_i.addr & REGION_MASK) == `SOC_CLINT_BASE) begin
        region = REGION_CLINT;
      end else if ((req_i.addr & REGION_MASK) == `SOC_PERIPH_BASE) begin
        region = REGION_PERIPH;
      end
    end
  end

  // Slot number inside the peripheral region
  assign slot = periph_slot_e'(req_i.addr[15:12]);

  // Target selects
  assign ram_sel_o   = (region == REGION_RAM);
  assign clint_sel_o = (region == REGION_CLINT);
  // Only the GPIO slot is populated
  assign gpio_sel_o  = (region == REGION_PERIPH) && (slot == SLOT_GPIO);

  // ========================================
  // Response mux
  // ========================================
  always_comb begin
    rsp_o = '0;
    case (region)
      // RAM carries its own delayed valid
      REGION_RAM: begin
        rsp_o = ram_rsp_i;
      end
      // Same-cycle answer
      REGION_CLINT: begin
        rsp_o.valid = 1'b1;
        rsp_o.rdata = clint_rdata_i;
      end
      REGION_PERIPH: begin
        rsp_o.valid = 1'b1;
        // Empty slots read as zero
        if (slot == SLOT_GPIO) begin
          rsp_o.rdata = gpio_rdata_i;
        end
      end
      // Unmapped, no response
      default: begin
        rsp_o = '0;
      end
    endcase
  end

endmodule

// ==== soc_ram.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_ram (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              sel_i,
  input  soc_pkg::bus_req_t req_i,
  output soc_pkg::bus_rsp_t rsp_o
);

  import soc_pkg::*;

  localparam int AW  = $clog2(`SOC_RAM_DEPTH);
  localparam int LAT = `SOC_RAM_LATENCY;

  // ========================================
  // Storage
  // ========================================
  logic [31:0]    mem [`SOC_RAM_DEPTH];
  logic [AW-1:0]  idx;

  // Word index from addr[11:2]
  assign idx = req_i.addr[AW+1:2];

  // Byte-strobed write, lands on every selected edge
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // ========================================
  // Latency model
  // ========================================
  logic           pending_q;
  logic [LAT-1:0] delay_q;
  logic           responded;

  // Last stage high while still selected
  assign responded = sel_i & delay_q[LAT-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else begin
      // Clear on response so a held request is not answered twice
      if (responded) begin
        delay_q <= '0;
      end else begin
        delay_q <= {delay_q[LAT-2:0], pending_q};
      end
      pending_q <= sel_i & ~responded;
    end
  end

  // Read data straight from the array
  assign rsp_o.valid = delay_q[LAT-1];
  assign rsp_o.rdata = mem[idx];

endmodule

// ==== soc_clint.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_clint (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              sel_i,
  input  soc_pkg::bus_req_t req_i,
  output logic [31:0]       rdata_o,
  output logic              timer_irq_o,
  output logic              sw_irq_o
);

  import soc_pkg::*;

  // High words sit one word above the base offset
  localparam logic [15:0] MTIMECMP_LO = `SOC_CLINT_MTIMECMP_OFF;
  localparam logic [15:0] MTIMECMP_HI = `SOC_CLINT_MTIMECMP_OFF + 16'h4;
  localparam logic [15:0] MTIME_LO    = `SOC_CLINT_MTIME_OFF;
  localparam logic [15:0] MTIME_HI    = `SOC_CLINT_MTIME_OFF + 16'h4;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic [15:0] off;
  logic        wr;

  assign off = req_i.addr[15:0];
  // Any strobe counts as a full-word write
  assign wr  = sel_i & (|req_i.wstrb);

  // ========================================
  // Registers
  // ========================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q    <= '0;
      // All ones keeps the timer interrupt low
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      // Free-running count
      mtime_q <= mtime_q + 64'd1;
      if (wr) begin
        case (off)
          `SOC_CLINT_MSIP_OFF: msip_q            <= req_i.wdata[0];
          MTIMECMP_LO:         mtimecmp_q[31:0]  <= req_i.wdata;
          MTIMECMP_HI:         mtimecmp_q[63:32] <= req_i.wdata;
          // Written half replaces the increment
          MTIME_LO:            mtime_q[31:0]     <= req_i.wdata;
          MTIME_HI:            mtime_q[63:32]    <= req_i.wdata;
          default:             ;
        endcase
      end
    end
  end

  // ========================================
  // Interrupts and read data
  // ========================================
  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign sw_irq_o    = msip_q;

  always_comb begin
    case (off)
      `SOC_CLINT_MSIP_OFF: rdata_o = {31'b0, msip_q};
      MTIMECMP_LO:         rdata_o = mtimecmp_q[31:0];
      MTIMECMP_HI:         rdata_o = mtimecmp_q[63:32];
      MTIME_LO:            rdata_o = mtime_q[31:0];
      MTIME_HI:            rdata_o = mtime_q[63:32];
      // Unmapped offsets read zero
      default:             rdata_o = '0;
    endcase
  end

endmodule

// ==== soc_gpio.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_gpio (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   sel_i,
  input  soc_pkg::bus_req_t      req_i,
  output logic [31:0]            rdata_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o,
  output logic                   irq_o
);

  import soc_pkg::*;

  localparam int W = `SOC_GPIO_W;

  logic [W-1:0] out_q, oe_q, ie_q, ip_q, in_q;
  logic [31:0]  bmask;
  logic [W-1:0] wmask, wval, rise, clr;
  logic [11:0]  off;
  logic         wr;

  assign off = req_i.addr[11:0];
  assign wr  = sel_i & (|req_i.wstrb);

  // Byte strobes widened to a bit mask
  assign bmask = {{8{req_i.wstrb[3]}}, {8{req_i.wstrb[2]}},
                  {8{req_i.wstrb[1]}}, {8{req_i.wstrb[0]}}};
  assign wmask = bmask[W-1:0];
  assign wval  = req_i.wdata[W-1:0];

  // Rising edge against the sampled copy
  assign rise = gpio_i & ~in_q;
  // Write one to clear pending bits
  assign clr  = (wr && off == `SOC_GPIO_IP_OFF) ? (wval & wmask) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_q <= '0;
      oe_q  <= '0;
      ie_q  <= '0;
      ip_q  <= '0;
      in_q  <= '0;
    end else begin
      in_q <= gpio_i;
      // New edge wins over the clear
      ip_q <= (ip_q & ~clr) | rise;
      if (wr && off == `SOC_GPIO_OUT_OFF) out_q <= (out_q & ~wmask) | (wval & wmask);
      if (wr && off == `SOC_GPIO_OE_OFF)  oe_q  <= (oe_q & ~wmask) | (wval & wmask);
      if (wr && off == `SOC_GPIO_IE_OFF)  ie_q  <= (ie_q & ~wmask) | (wval & wmask);
    end
  end

  // ========================================
  // Outputs and read mux
  // ========================================
  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign irq_o     = |(ip_q & ie_q);

  always_comb begin
    case (off)
      `SOC_GPIO_OUT_OFF: rdata_o = 32'(out_q);
      `SOC_GPIO_OE_OFF:  rdata_o = 32'(oe_q);
      `SOC_GPIO_IN_OFF:  rdata_o = 32'(in_q);
      `SOC_GPIO_IP_OFF:  rdata_o = 32'(ip_q);
      `SOC_GPIO_IE_OFF:  rdata_o = 32'(ie_q);
      default:           rdata_o = '0;
    endcase
  end

endmodule

// ==== soc_top.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  soc_pkg::bus_req_t      req_i,
  output soc_pkg::bus_rsp_t      rsp_o,
  input  logic [`SOC_GPIO_W-1:0] gpio_i,
  output logic [`SOC_GPIO_W-1:0] gpio_o,
  output logic [`SOC_GPIO_W-1:0] gpio_oe_o,
  output logic                   timer_irq_o,
  output logic                   sw_irq_o,
  output logic                   gpio_irq_o
);

  import soc_pkg::*;

  // ========================================
  // Fabric to target wiring
  // ========================================
  logic        ram_sel;
  logic        clint_sel;
  logic        gpio_sel;
  bus_rsp_t    ram_rsp;
  logic [31:0] clint_rdata;
  logic [31:0] gpio_rdata;

  // Decode and response mux
  soc_bus_fabric i_bus_fabric (
    .req_i         (req_i),
    .ram_rsp_i     (ram_rsp),
    .clint_rdata_i (clint_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .ram_sel_o     (ram_sel),
    .clint_sel_o   (clint_sel),
    .gpio_sel_o    (gpio_sel),
    .rsp_o         (rsp_o)
  );

  // Main RAM, fixed latency
  soc_ram i_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .sel_i  (ram_sel),
    .req_i  (req_i),
    .rsp_o  (ram_rsp)
  );

  // Timer and software interrupts
  soc_clint i_clint (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .sel_i       (clint_sel),
    .req_i       (req_i),
    .rdata_o     (clint_rdata),
    .timer_irq_o (timer_irq_o),
    .sw_irq_o    (sw_irq_o)
  );

  // Peripheral slot 4
  soc_gpio i_gpio (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sel_i     (gpio_sel),
    .req_i     (req_i),
    .rdata_o   (gpio_rdata),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o),
    .gpio_oe_o (gpio_oe_o),
    .irq_o     (gpio_irq_o)
  );

endmodule

// ==== soc_props.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module soc_props (
  input logic              clk_i,
  input logic              rst_ni,
  input soc_pkg::bus_req_t req_i,
  input soc_pkg::bus_rsp_t rsp_i,
  input logic              ram_sel_i,
  input logic              timer_irq_i
);

  import soc_pkg::*;

  localparam int LAT = `SOC_RAM_LATENCY;

  // Count of failed assertions
  int   fail_cnt = 0;
  logic sel_q;
  logic rsp_q;
  logic ram_start;

  // Previous-cycle RAM select and RAM response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sel_q <= 1'b0;
      rsp_q <= 1'b0;
    end else begin
      sel_q <= ram_sel_i;
      rsp_q <= ram_sel_i & rsp_i.valid;
    end
  end

  // New RAM request, also back to back after a response
  assign ram_start = ram_sel_i & ~(sel_q & ~rsp_q);

  // ========================================
  // RAM latency
  // ========================================
  // Valid sampled one edge after it appears, hence LAT+1
  a_ram_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ram_start |-> ##(LAT+1) rsp_i.valid)
    else begin
      $error("RAM response missing %0d edges after request", LAT);
      fail_cnt++;
    end

  // No early or repeated RAM answer
  a_ram_no_early: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ram_sel_i && rsp_i.valid) |-> $past(ram_start, LAT+1))
    else begin
      $error("RAM response without a request %0d edges before", LAT);
      fail_cnt++;
    end

  // ========================================
  // Bus and timer
  // ========================================
  a_rsp_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.valid |-> req_i.valid)
    else begin
      $error("Response valid while no request is presented");
      fail_cnt++;
    end

  // Timer interrupt holds once mtime passes mtimecmp
  a_timer_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    timer_irq_i |=> timer_irq_i)
    else begin
      $error("Timer interrupt dropped after rising");
      fail_cnt++;
    end

endmodule

bind soc_top soc_props i_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_i       (req_i),
  .rsp_i       (rsp_o),
  .ram_sel_i   (ram_sel),
  .timer_irq_i (timer_irq_o)
);

// ==== tb_soc_top.sv ====
`timescale 1ns/100ps
`include "soc_settings.svh"

module tb_soc_top;

  import soc_pkg::*;

  localparam int N_TESTS  = 6;
  localparam int RSP_WAIT = 50;
  localparam int WD_LIMIT = N_TESTS * 200 + 100;

  logic                   clk_i;
  logic                   rst_ni;
  bus_req_t               req;
  bus_rsp_t               rsp;
  logic [`SOC_GPIO_W-1:0] gpio_in;
  logic [`SOC_GPIO_W-1:0] gpio_out;
  logic [`SOC_GPIO_W-1:0] gpio_oe;
  logic                   timer_irq;
  logic                   sw_irq;
  logic                   gpio_irq;
  logic [31:0]            lfsr_q;
  int                     check_errors;
  int                     last_wait;
  logic [31:0]            ram_addr [8];
  logic [31:0]            ram_exp  [8];

  soc_top i_soc_top (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req),
    .rsp_o       (rsp),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .gpio_oe_o   (gpio_oe),
    .timer_irq_o (timer_irq),
    .sw_irq_o    (sw_irq),
    .gpio_irq_o  (gpio_irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Watchdog
  initial begin
    repeat (WD_LIMIT) @(posedge clk_i);
    $display("Timeout: run still going after %0d cycles", WD_LIMIT);
    $display("TEST FAIL");
    $finish;
  end

  // ========================================
  // Helpers
  // ========================================
  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] strobe_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  st);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (st[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] clint_addr(input logic [15:0] off);
    return `SOC_CLINT_BASE | {16'h0, off};
  endfunction

  // GPIO sits in slot 4
  function automatic logic [31:0] gpio_addr(input logic [11:0] off);
    return `SOC_PERIPH_BASE | 32'h0000_4000 | {20'h0, off};
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      check_errors++;
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      $display("Check failed at time %0t: %s", $time, what);
      check_errors++;
    end
  endtask

  // One transfer, entered on a falling edge; sample mid low phase
  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, output logic [31:0] rdata);
    int waited;
    waited    = 0;
    req.valid = 1'b1;
    req.addr  = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    #5;
    while (!rsp.valid && waited < RSP_WAIT) begin
      @(negedge clk_i);
      #5;
      waited++;
    end
    check_true("DUT gave no response to a request", rsp.valid);
    rdata     = rsp.rdata;
    last_wait = waited;
    // Hold through the closing rising edge
    @(negedge clk_i);
    req = '0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] st);
    logic [31:0] unused;
    bus_xfer(addr, data, st, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rd);
    bus_xfer(addr, 32'h0, 4'h0, rd);
  endtask

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [31:0] pat;
    logic [3:0]  st;
    int          k;
    int          bit_n;
    int          prop_errors;
    rst_ni       = 1'b0;
    req          = '0;
    gpio_in      = '0;
    check_errors = 0;
    last_wait    = 0;
    lfsr_q       = 32'ha21b;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Reset values
    check_true("rsp_o.valid high after reset", rsp.valid === 1'b0);
    check_true("timer_irq_o high after reset", timer_irq === 1'b0);
    check_true("sw_irq_o high after reset", sw_irq === 1'b0);
    check_true("gpio_irq_o high after reset", gpio_irq === 1'b0);
    check_eq("gpio_o", 32'h0, gpio_out);
    check_eq("gpio_oe_o", 32'h0, gpio_oe);

    // RAM round trip, index low bits keep addresses distinct
    for (int i = 0; i < 8; i++) begin
      wd          = take_bits(7);
      ram_addr[i] = `SOC_RAM_BASE | {20'h0, wd[6:0], 3'(i), 2'b00};
      wd          = take_bits(32);
      bus_write(ram_addr[i], wd, 4'hF);
      ram_exp[i]  = wd;
      pat         = take_bits(4);
      st          = (pat[3:0] == 4'h0) ? 4'h1 : pat[3:0];
      wd          = take_bits(32);
      bus_write(ram_addr[i], wd, st);
      ram_exp[i]  = strobe_merge(ram_exp[i], wd, st);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(ram_addr[i], rd);
      check_eq("ram rdata", ram_exp[i], rd);
    end

    // mtime low half, top nibble clear so no carry
    wd = take_bits(28);
    bus_write(clint_addr(`SOC_CLINT_MTIME_OFF), wd, 4'hF);
    pat = take_bits(3);
    k   = int'(pat[2:0]) + 2;
    repeat (k) @(negedge clk_i);
    bus_read(clint_addr(`SOC_CLINT_MTIME_OFF), rd);
    check_eq("mtime_lo", wd + 32'(k), rd);

    // Timer compare 20 ahead, high half first
    bus_read(clint_addr(`SOC_CLINT_MTIME_OFF), rd);
    pat = rd + 32'd20;
    bus_write(clint_addr(`SOC_CLINT_MTIMECMP_OFF + 16'h4), 32'h0, 4'hF);
    bus_write(clint_addr(`SOC_CLINT_MTIMECMP_OFF), pat, 4'hF);
    check_true("timer_irq_o high before mtime reached mtimecmp", !timer_irq);
    k = 0;
    while (!timer_irq && k < 40) begin
      @(negedge clk_i);
      k++;
    end
    check_true("timer_irq_o never rose", timer_irq);
    // Read in the first cycle with timer_irq_o high
    bus_read(clint_addr(`SOC_CLINT_MTIME_OFF), rd);
    check_eq("mtime at timer_irq_o rise", pat, rd);
    bus_write(clint_addr(`SOC_CLINT_MSIP_OFF), 32'h1, 4'hF);
    check_true("sw_irq_o did not rise after msip write", sw_irq === 1'b1);
    bus_read(clint_addr(`SOC_CLINT_MSIP_OFF), rd);
    check_eq("msip", 32'h1, rd);
    bus_write(clint_addr(`SOC_CLINT_MSIP_OFF), 32'h0, 4'hF);
    check_true("sw_irq_o did not fall after msip clear", sw_irq === 1'b0);

    // GPIO output and enable with strobes
    wd = take_bits(32);
    bus_write(gpio_addr(`SOC_GPIO_OUT_OFF), wd, 4'hF);
    rd  = wd;
    pat = take_bits(4);
    st  = (pat[3:0] == 4'h0) ? 4'h1 : pat[3:0];
    wd  = take_bits(32);
    bus_write(gpio_addr(`SOC_GPIO_OUT_OFF), wd, st);
    check_eq("gpio_o", strobe_merge(rd, wd, st), gpio_out);
    wd = take_bits(32);
    bus_write(gpio_addr(`SOC_GPIO_OE_OFF), wd, st);
    check_eq("gpio_oe_o", strobe_merge(32'h0, wd, st), gpio_oe);
    pat     = take_bits(32);
    gpio_in = pat;
    repeat (2) @(negedge clk_i);
    bus_read(gpio_addr(`SOC_GPIO_IN_OFF), rd);
    check_eq("gpio in", pat, rd);
    check_true("GPIO read was not answered in the same cycle", last_wait == 0);

    // GPIO edge interrupt
    gpio_in = '0;
    repeat (2) @(negedge clk_i);
    bus_write(gpio_addr(`SOC_GPIO_IP_OFF), 32'hFFFF_FFFF, 4'hF);
    pat   = take_bits(5);
    bit_n = int'(pat[4:0]);
    bus_write(gpio_addr(`SOC_GPIO_IE_OFF), 32'h1 << bit_n, 4'hF);
    gpio_in[bit_n] = 1'b1;
    repeat (2) @(negedge clk_i);
    bus_read(gpio_addr(`SOC_GPIO_IP_OFF), rd);
    check_eq("gpio pending", 32'h1 << bit_n, rd);
    check_true("gpio_irq_o did not rise on an enabled edge", gpio_irq === 1'b1);
    bus_write(gpio_addr(`SOC_GPIO_IP_OFF), 32'h1 << bit_n, 4'hF);
    check_true("gpio_irq_o stayed high after clearing", gpio_irq === 1'b0);

    // Empty slot 0
    bus_read(`SOC_PERIPH_BASE, rd);
    check_eq("empty slot rdata", 32'h0, rd);
    check_true("empty slot was not answered in the same cycle", last_wait == 0);

    @(negedge clk_i);
    prop_errors = i_soc_top.i_props.fail_cnt;
    $display("Errors: %0d check, %0d assertion", check_errors, prop_errors);
    if (check_errors == 0 && prop_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
soc_pkg.sv
soc_bus_fabric.sv
soc_ram.sv
soc_clint.sv
soc_gpio.sv
soc_top.sv
soc_props.sv
tb_soc_top.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_soc_top \
  && { ./obj_dir/Vtb_soc_top +verilator+error+limit+1000 > sim.log 2>&1 || true; }
grep -q "^TEST PASS$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
